//--- hdl/perf_cfg_pkg.sv
package perf_cfg_pkg;

  // ****************************************
  // monitor sizing
  // ****************************************

  // number of watched valid/ready links.
  localparam int NUM_CH = 4;

  // width of every statistics counter.
  localparam int COUNT_W = 16;

  // channel index width, kept at one bit or more.
  localparam int CH_W = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

  // ****************************************
  // derived values
  // ****************************************

  // saturation value of a counter.
  localparam logic [COUNT_W-1:0] COUNT_MAX = {COUNT_W{1'b1}};

endpackage

//--- hdl/perf_map_pkg.sv
package perf_map_pkg;

  import perf_cfg_pkg::*;

  // ****************************************
  // readout address layout
  // ****************************************

  // stat selector sits in the low bits of the address.
  localparam int SEL_W = 2;

  // number of statistics kept per channel.
  localparam int NUM_STAT = 2 ** SEL_W;

  // channel index above the selector.
  localparam int ADDR_W = CH_W + SEL_W;

  // ****************************************
  // stat selector codes
  // ****************************************

  localparam logic [SEL_W-1:0] STAT_START     = 2'd0;  // started transactions.
  localparam logic [SEL_W-1:0] STAT_ACCEPT    = 2'd1;  // accepted transactions.
  localparam logic [SEL_W-1:0] STAT_STALL     = 2'd2;  // total stall cycles.
  localparam logic [SEL_W-1:0] STAT_MAX_STALL = 2'd3;  // longest single stall.

endpackage

//--- hdl/rv_txn_detect.sv
module rv_txn_detect (
  input  logic clk,
  input  logic rst_n,
  input  logic valid,
  input  logic ready,
  output logic started,
  output logic stalled,
  output logic accepted
);

  // ****************************************
  // pending transaction state
  // ****************************************

  logic pending;  // valid held last cycle with no ready.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending <= 1'b0;
    end else begin
      pending <= valid && !ready;
    end
  end

  // ****************************************
  // event strobes
  // ****************************************

  // a new transaction only opens when nothing is pending.
  assign started  = valid && !pending;

  // first cycle with ready low counts as a start, later ones as stalls.
  assign stalled  = valid && !ready && pending;

  assign accepted = valid && ready;

  // a pending transfer keeps valid up until it is taken.
  a_valid_held : assert property (
    @(posedge clk) disable iff (!rst_n)
    pending |-> valid
  );

endmodule

//--- hdl/rv_stat_counter.sv
module rv_stat_counter import perf_cfg_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               clr,
  input  logic               started,
  input  logic               stalled,
  input  logic               accepted,
  output logic [COUNT_W-1:0] start_count,
  output logic [COUNT_W-1:0] accept_count,
  output logic [COUNT_W-1:0] stall_count,
  output logic [COUNT_W-1:0] max_stall
);

  logic [COUNT_W-1:0] run_count;  // stall cycles of the open transaction.
  logic [COUNT_W-1:0] run_now;    // run length including this cycle.

  // add one when enabled, holding at all ones.
  function automatic logic [COUNT_W-1:0] sat_inc(
    input logic [COUNT_W-1:0] value,
    input logic               en
  );
    if (en && (value != COUNT_MAX)) begin
      return value + 1'b1;
    end
    return value;
  endfunction

  // ****************************************
  // current stall run
  // ****************************************

  always_comb begin
    if (started) begin
      run_now = '0;  // first cycle is never a stall.
    end else begin
      run_now = sat_inc(run_count, stalled);
    end
  end

  // ****************************************
  // live counters
  // ****************************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      start_count  <= '0;
      accept_count <= '0;
      stall_count  <= '0;
      max_stall    <= '0;
      run_count    <= '0;
    end else if (clr) begin
      // strobes in the clear cycle are dropped.
      start_count  <= '0;
      accept_count <= '0;
      stall_count  <= '0;
      max_stall    <= '0;
      run_count    <= '0;
    end else begin
      start_count  <= sat_inc(start_count, started);
      accept_count <= sat_inc(accept_count, accepted);
      stall_count  <= sat_inc(stall_count, stalled);
      run_count    <= run_now;
      if (accepted && (run_now > max_stall)) begin
        max_stall <= run_now;  // new longest stall.
      end
    end
  end

  // ****************************************
  // checks
  // ****************************************

  // one transaction's stalls are part of the total.
  a_max_within_total : assert property (
    @(posedge clk) disable iff (!rst_n)
    max_stall <= stall_count
  );

  // a clear can split one open transaction, so one extra accept is allowed.
  a_accept_after_start : assert property (
    @(posedge clk) disable iff (!rst_n)
    ((start_count != COUNT_MAX) && (accept_count != COUNT_MAX))
      |-> ({1'b0, accept_count} <= ({1'b0, start_count} + 1'b1))
  );

endmodule

//--- hdl/rv_stat_readout.sv
module rv_stat_readout import perf_cfg_pkg::*, perf_map_pkg::*; (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           snap,
  input  logic [NUM_CH-1:0][COUNT_W-1:0] start_count,
  input  logic [NUM_CH-1:0][COUNT_W-1:0] accept_count,
  input  logic [NUM_CH-1:0][COUNT_W-1:0] stall_count,
  input  logic [NUM_CH-1:0][COUNT_W-1:0] max_stall,
  input  logic                           rd_en,
  input  logic [ADDR_W-1:0]              rd_addr,
  output logic                           rd_valid,
  output logic [COUNT_W-1:0]             rd_data
);

  // ****************************************
  // shadow registers
  // ****************************************

  logic [NUM_CH-1:0][NUM_STAT-1:0][COUNT_W-1:0] shadow;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      shadow <= '0;
    end else if (snap) begin
      for (int i = 0; i < NUM_CH; i++) begin
        shadow[i][STAT_START]     <= start_count[i];
        shadow[i][STAT_ACCEPT]    <= accept_count[i];
        shadow[i][STAT_STALL]     <= stall_count[i];
        shadow[i][STAT_MAX_STALL] <= max_stall[i];
      end
    end
  end

  // ****************************************
  // read port
  // ****************************************

  logic [CH_W-1:0]  rd_ch;   // channel field.
  logic [SEL_W-1:0] rd_sel;  // stat field.

  assign rd_ch  = rd_addr[ADDR_W-1:SEL_W];
  assign rd_sel = rd_addr[SEL_W-1:0];

  // reads see the shadow before any snap at the same edge.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
      rd_data  <= '0;
    end else begin
      rd_valid <= rd_en;
      if (rd_en) begin
        rd_data <= shadow[rd_ch][rd_sel];
      end
    end
  end

  // the address must name a watched channel.
  a_rd_ch_range : assert property (
    @(posedge clk) disable iff (!rst_n)
    rd_en |-> (rd_ch < NUM_CH)
  );

endmodule

//--- hdl/rv_perf_monitor.sv
module rv_perf_monitor import perf_cfg_pkg::*, perf_map_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [NUM_CH-1:0]  valid,
  input  logic [NUM_CH-1:0]  ready,
  input  logic               clr,
  input  logic               snap,
  input  logic               rd_en,
  input  logic [ADDR_W-1:0]  rd_addr,
  output logic               rd_valid,
  output logic [COUNT_W-1:0] rd_data
);

  // per-channel event strobes.
  logic [NUM_CH-1:0] started;
  logic [NUM_CH-1:0] stalled;
  logic [NUM_CH-1:0] accepted;

  // live counter values.
  logic [NUM_CH-1:0][COUNT_W-1:0] start_count;
  logic [NUM_CH-1:0][COUNT_W-1:0] accept_count;
  logic [NUM_CH-1:0][COUNT_W-1:0] stall_count;
  logic [NUM_CH-1:0][COUNT_W-1:0] max_stall;

  // ****************************************
  // channel slices
  // ****************************************

  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch
    rv_txn_detect rv_txn_detect_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .valid   (valid[ch]),
      .ready   (ready[ch]),
      .started (started[ch]),
      .stalled (stalled[ch]),
      .accepted(accepted[ch])
    );

    rv_stat_counter rv_stat_counter_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .clr         (clr),
      .started     (started[ch]),
      .stalled     (stalled[ch]),
      .accepted    (accepted[ch]),
      .start_count (start_count[ch]),
      .accept_count(accept_count[ch]),
      .stall_count (stall_count[ch]),
      .max_stall   (max_stall[ch])
    );
  end

  // ****************************************
  // readout
  // ****************************************

  rv_stat_readout rv_stat_readout_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .snap        (snap),
    .start_count (start_count),
    .accept_count(accept_count),
    .stall_count (stall_count),
    .max_stall   (max_stall),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data)
  );

endmodule

//--- bench/perf_model.svh
`ifndef PERF_MODEL_SVH
`define PERF_MODEL_SVH

// ****************************************
// reference model of the monitor
// ****************************************

localparam int unsigned SAT_LIMIT = (1 << COUNT_W) - 1;  // counters stop at all ones.

bit [NUM_CH-1:0] m_pend;                      // link holds an unaccepted transfer.
int unsigned     m_live   [NUM_CH][NUM_STAT];
int unsigned     m_shadow [NUM_CH][NUM_STAT];
int unsigned     m_run    [NUM_CH];           // stall cycles of the open transfer.

function automatic int unsigned bump(input int unsigned value, input bit en);
  if (en && (value < SAT_LIMIT)) begin
    return value + 1;
  end
  return value;
endfunction

function automatic void model_reset();
  m_pend = '0;
  for (int ch = 0; ch < NUM_CH; ch++) begin
    m_run[ch] = 0;
    for (int s = 0; s < NUM_STAT; s++) begin
      m_live[ch][s]   = 0;
      m_shadow[ch][s] = 0;
    end
  end
endfunction

// one clock edge, given the link levels seen during the cycle before it.
function automatic void model_step(input logic [NUM_CH-1:0] v, input logic [NUM_CH-1:0] r,
                                   input logic clr_i, input logic snap_i);
  bit          first;
  bit          waiting;
  bit          done;
  int unsigned run_now;
  if (snap_i) begin
    m_shadow = m_live;  // shadows see the counts from before this edge.
  end
  for (int ch = 0; ch < NUM_CH; ch++) begin
    first      = v[ch] && !m_pend[ch];
    waiting    = v[ch] && !r[ch] && m_pend[ch];
    done       = v[ch] && r[ch];
    m_pend[ch] = v[ch] && !r[ch];
    if (clr_i) begin
      m_run[ch] = 0;
      for (int s = 0; s < NUM_STAT; s++) begin
        m_live[ch][s] = 0;
      end
    end else begin
      run_now = first ? 0 : bump(m_run[ch], waiting);
      m_live[ch][STAT_START]  = bump(m_live[ch][STAT_START], first);
      m_live[ch][STAT_ACCEPT] = bump(m_live[ch][STAT_ACCEPT], done);
      m_live[ch][STAT_STALL]  = bump(m_live[ch][STAT_STALL], waiting);
      if (done && (run_now > m_live[ch][STAT_MAX_STALL])) begin
        m_live[ch][STAT_MAX_STALL] = run_now;
      end
      m_run[ch] = run_now;
    end
  end
endfunction

// value a read of this address should return from the shadows.
function automatic logic [COUNT_W-1:0] expected_value(input logic [ADDR_W-1:0] addr);
  int ch;
  int sel;
  ch  = int'(addr[ADDR_W-1:SEL_W]);
  sel = int'(addr[SEL_W-1:0]);
  return COUNT_W'(m_shadow[ch][sel]);
endfunction

`endif

//--- bench/rv_perf_monitor_tb.sv
module rv_perf_monitor_tb import perf_cfg_pkg::*, perf_map_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [NUM_CH-1:0] CH0_ONLY   = NUM_CH'(1);
  localparam logic [NUM_CH-1:0] CH1_ONLY   = NUM_CH'(2);
  localparam int                NUM_ADDR   = NUM_CH * NUM_STAT;
  localparam int                SAT_CYCLES = (1 << COUNT_W) + 16;  // long enough to saturate.
  localparam int                TIMEOUT    = 2 * (SAT_CYCLES + 2000);

  logic               clk;
  logic               rst_n;
  logic [NUM_CH-1:0]  valid;
  logic [NUM_CH-1:0]  ready;
  logic               clr;
  logic               snap;
  logic               rd_en;
  logic [ADDR_W-1:0]  rd_addr;
  logic               rd_valid;
  logic [COUNT_W-1:0] rd_data;

  int                seed;
  int                cycle_count;
  int                checks_done;
  int                value_errors;
  int                resp_errors;
  logic [NUM_CH-1:0] hold_mask;  // links forced to stall.

  `include "perf_model.svh"

  rv_perf_monitor rv_perf_monitor_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid   (valid),
    .ready   (ready),
    .clr     (clr),
    .snap    (snap),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_valid(rd_valid),
    .rd_data (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ****************************************
  // stimulus helpers
  // ****************************************

  task automatic drive_cycle(input logic [NUM_CH-1:0] v, input logic [NUM_CH-1:0] r,
                             input logic clr_i, input logic snap_i, input logic rd_i,
                             input logic [ADDR_W-1:0] addr_i);
    @(posedge clk);
    valid   <= v;
    ready   <= r;
    clr     <= clr_i;
    snap    <= snap_i;
    rd_en   <= rd_i;
    rd_addr <= addr_i;
  endtask

  // random link levels, a valid stays up until it is taken.
  task automatic random_cycle(input logic clr_i, input logic snap_i, input logic rd_i,
                              input logic [ADDR_W-1:0] addr_i);
    logic [NUM_CH-1:0] v_next;
    logic [NUM_CH-1:0] r_next;
    logic              hold;
    int                rnd;
    @(posedge clk);
    rnd = $random(seed);
    for (int ch = 0; ch < NUM_CH; ch++) begin
      hold       = valid[ch] && !ready[ch];
      v_next[ch] = hold_mask[ch] | hold | rnd[ch];
      r_next[ch] = !hold_mask[ch] && rnd[ch + NUM_CH];
    end
    valid   <= v_next;
    ready   <= r_next;
    clr     <= clr_i;
    snap    <= snap_i;
    rd_en   <= rd_i;
    rd_addr <= addr_i;
  endtask

  task automatic read_sweep(input bit busy);
    for (int a = 0; a < NUM_ADDR; a++) begin
      if (busy) begin
        random_cycle(1'b0, 1'b0, 1'b1, ADDR_W'(a));
      end else begin
        drive_cycle('0, '0, 1'b0, 1'b0, 1'b1, ADDR_W'(a));
      end
    end
  endtask

  task automatic check_value(input string what, input logic [COUNT_W-1:0] got,
                             input logic [COUNT_W-1:0] exp);
    checks_done++;
    if (got !== exp) begin
      value_errors++;
      $display("ERROR at %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
    end
  endtask

  // ****************************************
  // comparison process
  // ****************************************

  logic               held_rd;
  logic [ADDR_W-1:0]  held_addr;
  logic [COUNT_W-1:0] held_exp;

  always @(posedge clk) begin
    if (!rst_n) begin
      model_reset();
      held_rd = 1'b0;
    end else begin
      if (rd_valid !== held_rd) begin
        resp_errors++;
        if (held_rd) begin
          $display("no read response at %0t ns for address %0d", $time, held_addr);
        end else begin
          $display("read response at %0t ns without a read request", $time);
        end
      end else if (held_rd) begin
        check_value($sformatf("read of address %0d", held_addr), rd_data, held_exp);
      end
      held_rd   = rd_en;
      held_addr = rd_addr;
      held_exp  = expected_value(rd_addr);  // taken before a snap at this edge.
      model_step(valid, ready, clr, snap);
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
    $display("CHECKS FAILED");
    $finish;
  end

  // ****************************************
  // test sequence
  // ****************************************

  initial begin
    seed         = 32'ha5f7;
    checks_done  = 0;
    value_errors = 0;
    resp_errors  = 0;
    hold_mask    = '0;
    rst_n   <= 1'b0;
    valid   <= '0;
    ready   <= '0;
    clr     <= 1'b0;
    snap    <= 1'b0;
    rd_en   <= 1'b0;
    rd_addr <= '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // everything reads back as zero after reset.
    repeat (3) drive_cycle('0, '0, 1'b0, 1'b0, 1'b0, '0);
    drive_cycle('0, '0, 1'b0, 1'b1, 1'b0, '0);
    read_sweep(1'b0);
    repeat (3) drive_cycle('0, '0, 1'b0, 1'b0, 1'b0, '0);

    // directed transfers on channel 0.
    drive_cycle(CH0_ONLY, CH0_ONLY, 1'b0, 1'b0, 1'b0, '0);
    drive_cycle('0, '0, 1'b0, 1'b0, 1'b0, '0);
    drive_cycle(CH0_ONLY, '0, 1'b0, 1'b0, 1'b0, '0);  // start cycle, not a stall.
    repeat (3) drive_cycle(CH0_ONLY, '0, 1'b0, 1'b0, 1'b0, '0);
    drive_cycle(CH0_ONLY, CH0_ONLY, 1'b0, 1'b0, 1'b0, '0);
    repeat (3) drive_cycle(CH0_ONLY, CH0_ONLY, 1'b0, 1'b0, 1'b0, '0);
    drive_cycle('0, '0, 1'b0, 1'b1, 1'b0, '0);
    read_sweep(1'b0);
    check_value("directed starts", expected_value({CH_W'(0), STAT_START}), 16'd5);
    check_value("directed accepts", expected_value({CH_W'(0), STAT_ACCEPT}), 16'd5);
    check_value("directed stalls", expected_value({CH_W'(0), STAT_STALL}), 16'd3);
    check_value("directed longest stall", expected_value({CH_W'(0), STAT_MAX_STALL}), 16'd3);

    // random traffic; the read in each snap cycle sees the old shadow.
    for (int round = 0; round < 15; round++) begin
      repeat (80) random_cycle(1'b0, 1'b0, 1'b0, '0);
      random_cycle(1'b0, 1'b1, 1'b1, ADDR_W'(round));
      read_sweep(1'b1);
    end

    // clear in the middle of traffic.
    repeat (40) random_cycle(1'b0, 1'b0, 1'b0, '0);
    random_cycle(1'b1, 1'b0, 1'b0, '0);
    random_cycle(1'b0, 1'b1, 1'b0, '0);
    read_sweep(1'b1);
    for (int a = 0; a < NUM_ADDR; a++) begin
      check_value($sformatf("cleared address %0d", a), expected_value(ADDR_W'(a)), '0);
    end
    repeat (40) random_cycle(1'b0, 1'b0, 1'b0, '0);
    random_cycle(1'b0, 1'b1, 1'b0, '0);
    read_sweep(1'b1);

    // channel 1 stalls until its counters saturate.
    hold_mask = CH1_ONLY;
    repeat (SAT_CYCLES) random_cycle(1'b0, 1'b0, 1'b0, '0);
    hold_mask = '0;
    repeat (20) random_cycle(1'b0, 1'b0, 1'b0, '0);
    random_cycle(1'b0, 1'b1, 1'b0, '0);
    read_sweep(1'b1);
    check_value("saturated stall total", expected_value({CH_W'(1), STAT_STALL}), COUNT_MAX);
    repeat (3) random_cycle(1'b0, 1'b0, 1'b0, '0);

    $display("summary: %0d values checked, %0d value errors, %0d response errors",
             checks_done, value_errors, resp_errors);
    if ((value_errors == 0) && (resp_errors == 0)) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+bench
hdl/perf_cfg_pkg.sv
hdl/perf_map_pkg.sv
hdl/rv_txn_detect.sv
hdl/rv_stat_counter.sv
hdl/rv_stat_readout.sv
hdl/rv_perf_monitor.sv
bench/rv_perf_monitor_tb.sv

//--- Makefile
# Verilator flow for the valid/ready performance monitor.

TOP := rv_perf_monitor_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f sources.f --Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "simulation reported failures"; exit 1; \
	fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	verilator --lint-only --timing --top-module rv_perf_monitor \
		hdl/perf_cfg_pkg.sv hdl/perf_map_pkg.sv hdl/rv_txn_detect.sv \
		hdl/rv_stat_counter.sv hdl/rv_stat_readout.sv hdl/rv_perf_monitor.sv
	verilator --lint-only --timing --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir $(LOG)
